// ==== include/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath and address width
`define RV_XLEN 32

// register index width, 32 architectural registers
`define RV_REG_ADDR_W 5

`define RV_RESET_PC 32'h8000_0000

// data memory word index, addr bits 9:2
`define RV_DMEM_ADDR_W 8

`endif

// ==== hdl/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] xlen_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

  // major opcodes this core understands
  typedef enum logic [6:0] {
    op_imm = 7'b001_0011,
    lui    = 7'b011_0111,
    auipc  = 7'b001_0111,
    jal    = 7'b110_1111,
    jalr   = 7'b110_0111,
    load   = 7'b000_0011,
    store  = 7'b010_0011
  } opcode_e;

  // what the decoder made of the instruction
  typedef enum logic [2:0] {
    cls_addi,
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_load,
    cls_store,
    cls_nop    // anything else, no side effects
  } inst_class_e;

  // funct3 of loads and stores
  typedef enum logic [2:0] {
    sz_b  = 3'b000,
    sz_h  = 3'b001,
    sz_w  = 3'b010,
    sz_bu = 3'b100,
    sz_hu = 3'b101
  } mem_size_e;

endpackage

// ==== hdl/decode_ctrl_if.sv ====
`timescale 1ns/10ps

interface decode_ctrl_if import rv_pkg::*; ();

  inst_class_e cls;
  xlen_t       imm;   // sign extended, U imm already shifted
  mem_size_e   size;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  reg_addr_t   rd;

  modport decode (
    output cls, imm, size, rs1, rs2, rd
  );

  modport exec (
    input cls, imm
  );

  modport mem (
    input cls, size
  );

  modport result (
    input cls, size, rd
  );

endinterface

// ==== hdl/inst_decode.sv ====
`timescale 1ns/10ps

module inst_decode import rv_pkg::*; (
  input xlen_t        inst,
  decode_ctrl_if.decode ctrl
);

  opcode_e    opcode;
  logic [2:0] funct3;

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_u;
  xlen_t imm_j;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];

  // register fields sit at fixed positions in every format
  assign ctrl.rd  = inst[11:7];
  assign ctrl.rs1 = inst[19:15];
  assign ctrl.rs2 = inst[24:20];

  assign ctrl.size = mem_size_e'(funct3);

  // immediates, bit 31 is always the sign
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl.cls = cls_nop;
    ctrl.imm = '0;
    case (opcode)
      op_imm: begin
        if (funct3 == 3'b000) begin // only addi kept
          ctrl.cls = cls_addi;
          ctrl.imm = imm_i;
        end
      end
      lui: begin
        ctrl.cls = cls_lui;
        ctrl.imm = imm_u;
      end
      auipc: begin
        ctrl.cls = cls_auipc;
        ctrl.imm = imm_u;
      end
      jal: begin
        ctrl.cls = cls_jal;
        ctrl.imm = imm_j;
      end
      jalr: begin
        ctrl.cls = cls_jalr;
        ctrl.imm = imm_i;
      end
      load: begin
        ctrl.cls = cls_load;
        ctrl.imm = imm_i;
      end
      store: begin
        ctrl.cls = cls_store;
        ctrl.imm = imm_s;   // split immediate
      end
      default: begin
        ctrl.cls = cls_nop;   // unknown opcode
        ctrl.imm = '0;
      end
    endcase
  end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/10ps

module register_file import rv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t waddr,
  input  logic      wen,
  input  xlen_t     wdata,
  output xlen_t     rs1_data,
  output xlen_t     rs2_data
);

  localparam int NUM_REGS = 1 << $bits(reg_addr_t);

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads as zero whatever is stored
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/exec_unit.sv ====
`timescale 1ns/10ps
`include "rv_settings.svh"

module exec_unit import rv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  decode_ctrl_if.exec ctrl,
  input  xlen_t       rs1_data,
  output xlen_t       pc,
  output xlen_t       sum,
  output xlen_t       link
);

  xlen_t op1;
  xlen_t next_pc;

  // first adder operand
  always_comb begin
    case (ctrl.cls)
      cls_auipc, cls_jal: op1 = pc;
      cls_addi, cls_jalr, cls_load, cls_store: op1 = rs1_data;
      default: op1 = '0;   // lui passes the immediate through
    endcase
  end

  // one adder serves results, jump targets and memory addresses
  assign sum  = op1 + ctrl.imm;
  assign link = pc + 32'd4;

  always_comb begin
    case (ctrl.cls)
      cls_jal, cls_jalr: next_pc = {sum[31:1], 1'b0};
      default: next_pc = link;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// ==== hdl/data_memory.sv ====
`timescale 1ns/10ps
`include "rv_settings.svh"

module data_memory import rv_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  decode_ctrl_if.mem ctrl,
  input  xlen_t      addr,
  input  xlen_t      wdata,
  output xlen_t      rdata
);

  localparam int DEPTH = 1 << `RV_DMEM_ADDR_W;

  xlen_t mem [DEPTH];

  logic [`RV_DMEM_ADDR_W-1:0] word_idx;
  logic [3:0]                 byte_mask;
  xlen_t                      lane_data;

  assign word_idx = addr[`RV_DMEM_ADDR_W+1:2];   // upper bits ignored

  // lanes written per size and offset, misaligned gives no mask
  always_comb begin
    case ({ctrl.size, addr[1:0]})
      {sz_b, 2'b00}: byte_mask = 4'b0001;
      {sz_b, 2'b01}: byte_mask = 4'b0010;
      {sz_b, 2'b10}: byte_mask = 4'b0100;
      {sz_b, 2'b11}: byte_mask = 4'b1000;
      {sz_h, 2'b00}: byte_mask = 4'b0011;
      {sz_h, 2'b10}: byte_mask = 4'b1100;
      {sz_w, 2'b00}: byte_mask = 4'b1111;
      default:       byte_mask = 4'b0000;
    endcase
  end

  // move store data up to the addressed lane
  assign lane_data = wdata << {addr[1:0], 3'b000};

  always_ff @(posedge clk) begin
    if (!reset && ctrl.cls == cls_store) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_mask[i]) begin
          mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
        end
      end
    end
  end

  assign rdata = mem[word_idx];   // whole word, lane pick happens later

endmodule

// ==== hdl/writeback_unit.sv ====
`timescale 1ns/10ps

module writeback_unit import rv_pkg::*; (
  input  logic          reset,
  decode_ctrl_if.result ctrl,
  input  xlen_t         sum,
  input  xlen_t         link,
  input  xlen_t         mem_rdata,
  output logic          rf_wen,
  output reg_addr_t     rf_waddr,
  output xlen_t         rf_wdata
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  xlen_t       load_data;
  logic        writes_rd;

  assign ld_byte = mem_rdata[{sum[1:0], 3'b000} +: 8];
  assign ld_half = sum[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  // misaligned halfword or word loads read as zero
  always_comb begin
    case (ctrl.size)
      sz_b:    load_data = {{24{ld_byte[7]}}, ld_byte};
      sz_bu:   load_data = {24'h00_0000, ld_byte};
      sz_h:    load_data = sum[0] ? '0 : {{16{ld_half[15]}}, ld_half};
      sz_hu:   load_data = sum[0] ? '0 : {16'h0000, ld_half};
      sz_w:    load_data = (sum[1:0] != 2'b00) ? '0 : mem_rdata;
      default: load_data = '0;
    endcase
  end

  always_comb begin
    case (ctrl.cls)
      cls_jal, cls_jalr: rf_wdata = link;   // return address
      cls_load:          rf_wdata = load_data;
      default:           rf_wdata = sum;
    endcase
  end

  always_comb begin
    case (ctrl.cls)
      cls_addi, cls_lui, cls_auipc, cls_jal, cls_jalr, cls_load: writes_rd = 1'b1;
      default: writes_rd = 1'b0;   // store and nop
    endcase
  end

  assign rf_wen   = writes_rd && (ctrl.rd != '0) && !reset;
  assign rf_waddr = ctrl.rd;

endmodule

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/10ps

module rv_core_top import rv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  xlen_t     inst,
  output xlen_t     pc,
  output logic      retire_wen,
  output reg_addr_t retire_rd,
  output xlen_t     retire_data
);

  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     sum;
  xlen_t     link;
  xlen_t     mem_rdata;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  xlen_t     rf_wdata;

  decode_ctrl_if ctrl ();

  inst_decode u_decode (
    .inst (inst),
    .ctrl (ctrl.decode)
  );

  register_file u_regs (
    .clk      (clk),
    .reset    (reset),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .waddr    (rf_waddr),
    .wen      (rf_wen),
    .wdata    (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit u_exec (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl.exec),
    .rs1_data (rs1_data),
    .pc       (pc),
    .sum      (sum),
    .link     (link)
  );

  // adder output doubles as the memory address
  data_memory u_dmem (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl.mem),
    .addr  (sum),
    .wdata (rs2_data),
    .rdata (mem_rdata)
  );

  writeback_unit u_wb (
    .reset     (reset),
    .ctrl      (ctrl.result),
    .sum       (sum),
    .link      (link),
    .mem_rdata (mem_rdata),
    .rf_wen    (rf_wen),
    .rf_waddr  (rf_waddr),
    .rf_wdata  (rf_wdata)
  );

  // retire ports mirror the register write in the same cycle
  assign retire_wen  = rf_wen;
  assign retire_rd   = rf_waddr;
  assign retire_data = rf_wdata;

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // half period per toggle
  always begin
    #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

// ==== testbench/rv_checker.sv ====
`timescale 1ns/10ps
`include "rv_settings.svh"

module rv_checker import rv_pkg::*; (
  input logic      clk,
  input logic      reset,
  input xlen_t     pc,
  input logic      retire_wen,
  input reg_addr_t retire_rd
);

  int fail_count = 0;   // summed into the testbench error count

  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("pc not word aligned: %h", pc);
    end

  // x0 is never reported as written
  no_x0_retire: assert property (@(posedge clk) retire_wen |-> retire_rd != '0)
    else begin
      fail_count++;
      $error("retire reported for x0");
    end

  pc_after_reset: assert property (@(posedge clk) reset |=> pc == `RV_RESET_PC)
    else begin
      fail_count++;
      $error("pc %h is not the reset pc after reset", pc);
    end

endmodule

// ==== testbench/tb_top.sv ====
`timescale 1ns/10ps
`include "rv_settings.svh"

module tb_top import rv_pkg::*; ();

  localparam int RESET_CYCLES = 5;
  localparam int N_ARITH  = 40;
  localparam int N_JUMP   = 20;
  localparam int N_WORD   = 16;
  localparam int N_SUB    = 12;
  localparam int N_CORNER = 8;
  // instructions issued by all tests including register setup
  localparam int INST_TOTAL = 1 + N_ARITH + 3 * N_JUMP + 8 * N_WORD + 22 * N_SUB
                              + 15 * N_CORNER;
  localparam int CYCLE_LIMIT = INST_TOTAL + RESET_CYCLES + 100;

  logic      clk;
  logic      reset;
  xlen_t     inst;
  xlen_t     pc;
  logic      retire_wen;
  reg_addr_t retire_rd;
  xlen_t     retire_data;

  // reference model state
  xlen_t      regs_m [32];
  logic [7:0] mem_m [1024];   // byte array indexed by addr bits 9:0
  xlen_t      pc_m;

  logic [15:0] lfsr = 16'd51;
  logic [6:0]  junk_ops [4] = '{7'h33, 7'h63, 7'h73, 7'h0f};   // outside the kept set
  xlen_t       addr_list [N_WORD];
  int cycles = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_start_errors = 0;

  tb_clock_gen #(.PERIOD_NS(8.0)) u_clk (.clk(clk));

  rv_core_top dut0 (
    .clk         (clk),
    .reset       (reset),
    .inst        (inst),
    .pc          (pc),
    .retire_wen  (retire_wen),
    .retire_rd   (retire_rd),
    .retire_data (retire_data)
  );

  bind rv_core_top rv_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .retire_wen (retire_wen),
    .retire_rd  (retire_rd)
  );

  // fibonacci lfsr with taps 16 14 13 11
  function automatic xlen_t rand_bits(input int n);
    xlen_t r;
    logic  fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic xlen_t itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic xlen_t stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic xlen_t utype_word(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic xlen_t jtype_word(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic xlen_t load_model(input logic [2:0] f3, input xlen_t a);
    logic [9:0] b;
    xlen_t      half;
    xlen_t      word;
    b    = a[9:0];
    half = {16'h0000, mem_m[b + 10'd1], mem_m[b]};
    word = {mem_m[b + 10'd3], mem_m[b + 10'd2], half[15:0]};
    case (f3)
      3'b000:  return {{24{mem_m[b][7]}}, mem_m[b]};
      3'b100:  return {24'h00_0000, mem_m[b]};
      3'b001:  return a[0] ? '0 : {{16{half[15]}}, half[15:0]};
      3'b101:  return a[0] ? '0 : half;
      3'b010:  return (a[1:0] != 2'b00) ? '0 : word;
      default: return '0;
    endcase
  endfunction

  // misaligned halfword and word stores leave memory alone
  task automatic store_model(input logic [2:0] f3, input xlen_t a, input xlen_t v);
    logic [9:0] b;
    b = a[9:0];
    if (f3 == 3'b000) begin
      mem_m[b] = v[7:0];
    end else if (f3 == 3'b001 && !a[0]) begin
      mem_m[b]         = v[7:0];
      mem_m[b + 10'd1] = v[15:8];
    end else if (f3 == 3'b010 && a[1:0] == 2'b00) begin
      for (int k = 0; k < 4; k++) begin
        mem_m[b + 10'(k)] = v[8*k +: 8];
      end
    end
  endtask

  task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic model_check(input xlen_t word);
    logic [4:0] rd;
    logic [2:0] f3;
    xlen_t      v1;
    xlen_t      v2;
    xlen_t      imm_i;
    xlen_t      imm_j;
    xlen_t      wval;
    xlen_t      nxt;
    logic       wr;
    rd    = word[11:7];
    f3    = word[14:12];
    v1    = regs_m[word[19:15]];
    v2    = regs_m[word[24:20]];
    imm_i = {{20{word[31]}}, word[31:20]};
    imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    wr    = 1'b1;
    wval  = '0;
    nxt   = pc_m + 32'd4;
    case (word[6:0])
      7'h13: begin
        wr   = (f3 == 3'b000);   // only addi among op_imm
        wval = v1 + imm_i;
      end
      7'h37: wval = {word[31:12], 12'h000};
      7'h17: wval = pc_m + {word[31:12], 12'h000};
      7'h6f: begin
        wval = pc_m + 32'd4;
        nxt  = (pc_m + imm_j) & ~32'h1;
      end
      7'h67: begin
        wval = pc_m + 32'd4;
        nxt  = (v1 + imm_i) & ~32'h1;
      end
      7'h03: wval = load_model(f3, v1 + imm_i);
      7'h23: begin
        wr = 1'b0;
        store_model(f3, v1 + {{20{word[31]}}, word[31:25], word[11:7]}, v2);
      end
      default: wr = 1'b0;
    endcase
    if (rd == 5'd0) begin
      wr = 1'b0;
    end
    check_value("pc", pc_m, pc);
    check_value("retire_wen", 32'(wr), 32'(retire_wen));
    if (wr) begin
      check_value("retire_rd", 32'(rd), 32'(retire_rd));
      check_value("retire_data", wval, retire_data);
      regs_m[rd] = wval;
    end
    pc_m = nxt;
  endtask

  // one instruction per cycle with results sampled mid cycle
  task automatic issue(input xlen_t word);
    @(posedge clk);
    inst <= word;
    @(negedge clk);
    model_check(word);
  endtask

  task automatic set_reg(input logic [4:0] rd, input xlen_t value);
    xlen_t upper;
    upper = value + 32'h800;   // addi sign extends the low part
    issue(utype_word(upper[31:12], rd, 7'h37));
    issue(itype_word(value[11:0], rd, 3'b000, rd, 7'h13));
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s done with %0d errors", name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    xlen_t      base;
    logic [4:0] rd;
    logic [2:0] f3;
    logic [1:0] sel;
    int         mis_h;
    int         mis_w;
    reset = 1'b1;
    inst  = itype_word(12'd1, 5'd0, 3'b000, 5'd1, 7'h13);   // would retire without reset
    pc_m  = `RV_RESET_PC;
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = '0;
    end

    repeat (RESET_CYCLES) begin
      @(posedge clk);
      @(negedge clk);
      check_value("pc", `RV_RESET_PC, pc);
      check_value("retire_wen", 32'd0, 32'(retire_wen));
    end
    @(posedge clk);
    reset <= 1'b0;
    inst  <= itype_word(12'd5, 5'd0, 3'b000, 5'd1, 7'h13);
    @(negedge clk);
    model_check(itype_word(12'd5, 5'd0, 3'b000, 5'd1, 7'h13));
    end_test("reset");

    for (int i = 0; i < N_ARITH; i++) begin
      sel = 2'(rand_bits(2));
      rd  = 5'(rand_bits(5));
      if (rd == 5'd0) begin
        rd = 5'd1;
      end
      case (sel)
        2'd1:    issue(utype_word(20'(rand_bits(20)), rd, 7'h37));
        2'd2:    issue(utype_word(20'(rand_bits(20)), rd, 7'h17));
        default: issue(itype_word(12'(rand_bits(12)), 5'(rand_bits(5)), 3'b000, rd, 7'h13));
      endcase
    end
    end_test("arith");

    for (int i = 0; i < N_JUMP; i++) begin
      rd = 5'(rand_bits(5)) | 5'd1;
      set_reg(5'd5, rand_bits(32) & ~32'h3);
      if (rand_bits(1) == 32'd1) begin
        issue(jtype_word({19'(rand_bits(19)), 2'b00}, rd));
      end else begin
        // bit 1 kept clear so the target stays word aligned
        issue(itype_word({10'(rand_bits(10)), 1'b0, 1'(rand_bits(1))}, 5'd5, 3'b000,
                         rd, 7'h67));
      end
    end
    end_test("jumps");

    for (int i = 0; i < N_WORD; i++) begin
      addr_list[i] = rand_bits(32) & ~32'h3;
      set_reg(5'd5, addr_list[i]);
      set_reg(5'd6, rand_bits(32));
      issue(stype_word(12'd0, 5'd6, 5'd5, 3'b010));
    end
    for (int i = 0; i < N_WORD; i++) begin
      set_reg(5'd5, addr_list[i]);
      issue(itype_word(12'd0, 5'd5, 3'b010, 5'd7, 7'h03));
    end
    end_test("word_mem");

    for (int i = 0; i < N_SUB; i++) begin
      base = rand_bits(32) & ~32'h3;
      set_reg(5'd5, base);
      set_reg(5'd6, rand_bits(32));
      issue(stype_word(12'd0, 5'd6, 5'd5, 3'b010));   // known word first
      set_reg(5'd6, rand_bits(32));
      issue(stype_word(12'(i % 4), 5'd6, 5'd5, 3'b000));
      // halfword in the other half of the word from the byte
      issue(stype_word((i % 4 < 2) ? 12'd2 : 12'd0, 5'd6, 5'd5, 3'b001));
      for (int off = 0; off < 4; off++) begin
        issue(itype_word(12'(off), 5'd5, 3'b000, 5'd7, 7'h03));
        issue(itype_word(12'(off), 5'd5, 3'b100, 5'd8, 7'h03));
      end
      for (int off = 0; off < 4; off += 2) begin
        issue(itype_word(12'(off), 5'd5, 3'b001, 5'd7, 7'h03));
        issue(itype_word(12'(off), 5'd5, 3'b101, 5'd8, 7'h03));
      end
      issue(itype_word(12'd0, 5'd5, 3'b010, 5'd9, 7'h03));
    end
    end_test("subword_mem");

    for (int i = 0; i < N_CORNER; i++) begin
      base  = rand_bits(32) & ~32'h3;
      mis_h = (i % 2 == 0) ? 1 : 3;
      mis_w = 1 + i % 3;
      set_reg(5'd5, base);
      set_reg(5'd6, rand_bits(32));
      issue(stype_word(12'd0, 5'd6, 5'd5, 3'b010));
      set_reg(5'd6, rand_bits(32));
      issue(stype_word(12'(mis_h), 5'd6, 5'd5, 3'b001));
      issue(stype_word(12'(mis_w), 5'd6, 5'd5, 3'b010));
      issue(itype_word(12'd0, 5'd5, 3'b010, 5'd7, 7'h03));   // word unchanged
      issue(itype_word(12'(mis_h), 5'd5, 3'b001, 5'd8, 7'h03));
      issue(itype_word(12'(mis_w), 5'd5, 3'b010, 5'd9, 7'h03));
      issue(itype_word(12'(rand_bits(12)), 5'd5, 3'b000, 5'd0, 7'h13));
      sel = 2'(rand_bits(2));
      issue({25'(rand_bits(25)), junk_ops[sel]});
      f3 = 3'(rand_bits(3));
      if (f3 == 3'b000) begin
        f3 = 3'b001;
      end
      issue(itype_word(12'(rand_bits(12)), 5'd5, f3, 5'd10, 7'h13));
    end
    end_test("corners");

    // pc after the last instruction
    @(posedge clk);
    @(negedge clk);
    check_value("pc", pc_m, pc);

    errors = errors + dut0.u_checker.fail_count;
    $display("%0d tests, %0d checks, %0d assertion failures, %0d errors", tests, checks,
             dut0.u_checker.fail_count, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
hdl/rv_pkg.sv
hdl/decode_ctrl_if.sv
hdl/inst_decode.sv
hdl/register_file.sv
hdl/exec_unit.sv
hdl/data_memory.sv
hdl/writeback_unit.sv
hdl/rv_core_top.sv
testbench/tb_clock_gen.sv
testbench/rv_checker.sv
testbench/tb_top.sv
